//--- project.f
logic/filter_cond_pkg.sv
logic/filter_cond_config.sv
logic/filter_cond_kernel.sv
logic/filter_cond_gate.sv
logic/filter_cond_engine.sv
test/tb_clock_gen.sv
test/tb_filter_cond_engine.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the filter condition testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f project.f \
  --top-module tb_filter_cond_engine -o tb_sim

# The pipe keeps going on a simulator error so the log search decides
./obj_dir/tb_sim 2>&1 | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  echo "Run failed, see $LOG"
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "Run ended without a result line, see $LOG"
  exit 1
fi
echo "Run passed"

//--- test/tb_filter_cond_engine.sv
// --------------------
// Filter condition engine testbench
// Reference model, output scoreboard and counter checks
// --------------------

`timescale 1ns/1ps

module tb_filter_cond_engine;

  import filter_cond_pkg::*;

  localparam int reset_cycles = 10;
  localparam int num_phases   = 6;
  // Packets per phase, in phase order
  localparam int pkt_cycles   = 16 + 4 * 24 + (4 * 6 + 8 + 8) + 5 * 8 + 3 * 8 + 64;
  // Register groups written over the run, each about 12 cycles with drain
  localparam int cfg_cycles   = 19 * 12;
  localparam int timeout_cycles = reset_cycles + pkt_cycles + cfg_cycles + num_phases * 200;

  localparam ops_mask_t identity_ops = 16'h8421;

  logic                   ap_clk;
  logic                   rst_n;
  logic                   cfg_we;
  cfg_addr_t              cfg_addr;
  logic [31:0]            cfg_wdata;
  logic                   in_valid;
  engine_packet_data_t    in_data;
  logic                   out_valid;
  engine_packet_data_t    out_data;
  logic [31:0]            pass_count;
  logic [31:0]            drop_count;

  // Configuration as last written
  filter_op_t             shadow_op;
  logic [num_fields-1:0]  shadow_fmask;
  logic [num_fields-1:0]  shadow_cmask;
  logic [field_width-1:0] shadow_cval;
  ops_mask_t              shadow_ops;

  // Scoreboard
  engine_packet_data_t    exp_q[$];
  int                     exp_cycle_q[$];
  engine_packet_data_t    head_data;
  int                     head_cycle;
  int                     exp_pass_tally = 0;
  int                     exp_drop_tally = 0;
  int                     value_errors = 0;
  int                     protocol_errors = 0;
  int                     cycle_count = 0;
  integer                 seed = 32'hfb1b4681;
  filter_op_t             cmp_ops[4] = '{filter_gt, filter_lt, filter_eq, filter_not_eq};

  tb_clock_gen u_clock (.ap_clk(ap_clk));

  filter_cond_engine UUT (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .pass_count (pass_count),
    .drop_count (drop_count)
  );

  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic void ref_filter(
    input  engine_packet_data_t pkt,
    output logic                exp_pass,
    output engine_packet_data_t exp_data
  );
    engine_packet_data_t    operand;
    engine_packet_data_t    original;
    logic [field_width-1:0] a;
    logic [field_width-1:0] b;
    logic                   lane_ok;
    int                     src;
    for (int lane = 0; lane < num_fields; lane++) begin
      src = -1;
      // Scan from the top so the highest set bit is found first
      for (int j = num_fields - 1; j >= 0; j--) begin
        if (src < 0 && shadow_ops[lane][j]) begin
          src = j;
        end
      end
      if (src < 0) begin
        original[lane] = pkt[lane];
      end else begin
        original[lane] = pkt[src];
      end
      if (shadow_cmask[lane]) begin
        operand[lane] = shadow_cval;
      end else if (src >= 0) begin
        operand[lane] = pkt[src];
      end else begin
        operand[lane] = '0;
      end
    end
    exp_pass = 1'b1;
    if (shadow_op inside {filter_gt, filter_lt, filter_eq, filter_not_eq}) begin
      for (int lane = 0; lane < num_fields; lane++) begin
        a = operand[lane];
        b = operand[(lane + 1) % num_fields];
        case (shadow_op)
          filter_gt: lane_ok = a > b;
          filter_lt: lane_ok = a < b;
          filter_eq: lane_ok = a == b;
          default:   lane_ok = a != b;
        endcase
        if (shadow_fmask[lane] && !lane_ok) begin
          exp_pass = 1'b0;
        end
      end
    end
    exp_data = (shadow_op == filter_nop) ? operand : original;
  endfunction

  function automatic logic [field_width-1:0] rand_field();
    return $random(seed);
  endfunction

  function automatic engine_packet_data_t rand_packet();
    engine_packet_data_t pkt;
    for (int i = 0; i < num_fields; i++) begin
      pkt[i] = rand_field();
    end
    return pkt;
  endfunction

  function automatic engine_packet_data_t equal_packet(input logic [field_width-1:0] value);
    return {num_fields{value}};
  endfunction

  // --------------------
  // Checks
  // --------------------
  task automatic check_packet(input engine_packet_data_t got, input engine_packet_data_t exp,
                              input string what);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Each output must match the oldest expected packet, three edges after its input
  always @(negedge ap_clk) begin
    if (rst_n === 1'b1 && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        protocol_errors++;
        $display("Output packet %h came out at %0t while none was expected", out_data, $time);
      end else begin
        head_data  = exp_q.pop_front();
        head_cycle = exp_cycle_q.pop_front();
        check_packet(out_data, head_data, "output packet");
        check_count(cycle_count + 1, head_cycle + kernel_latency, "output edge");
      end
    end
  end

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic send_packet(input engine_packet_data_t pkt);
    logic                pass;
    engine_packet_data_t res;
    ref_filter(pkt, pass, res);
    @(posedge ap_clk);
    in_valid <= 1'b1;
    in_data  <= pkt;
    if (pass) begin
      exp_q.push_back(res);
      // Edge that samples this packet
      exp_cycle_q.push_back(cycle_count + 2);
      exp_pass_tally++;
    end else begin
      exp_drop_tally++;
    end
  endtask

  task automatic drain_pipe();
    @(posedge ap_clk);
    in_valid <= 1'b0;
    repeat (kernel_latency) @(posedge ap_clk);
  endtask

  task automatic write_reg(input cfg_addr_t addr, input logic [31:0] data);
    @(posedge ap_clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
  endtask

  task automatic set_config(input filter_op_t op, input logic [num_fields-1:0] fmask,
                            input logic [num_fields-1:0] cmask,
                            input logic [field_width-1:0] cval, input ops_mask_t ops);
    drain_pipe();
    shadow_op    = op;
    shadow_fmask = fmask;
    shadow_cmask = cmask;
    shadow_cval  = cval;
    shadow_ops   = ops;
    write_reg(cfg_operation, {29'd0, op});
    write_reg(cfg_filter_mask, {28'd0, fmask});
    write_reg(cfg_const_mask, {28'd0, cmask});
    write_reg(cfg_const_value, cval);
    write_reg(cfg_ops_mask, {16'd0, ops});
    @(posedge ap_clk);
    cfg_we <= 1'b0;
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    rst_n     <= 1'b0;
    cfg_we    <= 1'b0;
    cfg_addr  <= cfg_operation;
    cfg_wdata <= '0;
    in_valid  <= 1'b0;
    in_data   <= '0;
    shadow_op    = filter_nop;
    shadow_fmask = '0;
    shadow_cmask = '0;
    shadow_cval  = '0;
    shadow_ops   = '0;
    repeat (reset_cycles) @(posedge ap_clk);
    rst_n <= 1'b1;

    // Reset state, default config zeroes every field
    @(negedge ap_clk);
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_count(pass_count, 32'd0, "pass_count after reset");
    check_count(drop_count, 32'd0, "drop_count after reset");
    repeat (16) send_packet(rand_packet());

    // Identity mapping under each compare
    for (int k = 0; k < 4; k++) begin
      set_config(cmp_ops[k], 4'hf, 4'h0, 32'd0, identity_ops);
      repeat (20) send_packet(rand_packet());
      repeat (4) send_packet(equal_packet(rand_field()));
    end

    // Constant against its neighbour, one lane at a time
    for (int lane = 0; lane < num_fields; lane++) begin
      set_config(filter_gt, 4'b0001 << lane, 4'b0001 << lane, 32'h8000_0000, identity_ops);
      repeat (6) send_packet(rand_packet());
    end
    // Multi-bit rows, lanes 0 and 1 both take field 3
    set_config(filter_eq, 4'b0001, 4'h0, 32'd0, 16'h36f9);
    repeat (8) send_packet(rand_packet());
    set_config(filter_nop, 4'hf, 4'b0101, 32'h5a5a_1234, 16'h1008);
    repeat (8) send_packet(rand_packet());

    // Partial filter masks
    set_config(filter_not_eq, 4'b0001, 4'h0, 32'd0, identity_ops);
    repeat (8) send_packet(rand_packet());
    set_config(filter_lt, 4'b0110, 4'h0, 32'd0, identity_ops);
    repeat (8) send_packet(rand_packet());
    set_config(filter_gt, 4'b1010, 4'h0, 32'd0, identity_ops);
    repeat (8) send_packet(rand_packet());
    set_config(filter_lt, 4'b0011, 4'h0, 32'd0, identity_ops);
    repeat (8) send_packet(rand_packet());
    set_config(filter_gt, 4'b0000, 4'h0, 32'd0, identity_ops);
    repeat (8) send_packet(rand_packet());

    // Undefined codes, lane 0 held at zero so any real compare would drop
    for (int code = 5; code < 8; code++) begin
      set_config(filter_op_t'(code), 4'hf, 4'b0001, 32'd0, 16'h1248);
      repeat (6) send_packet(rand_packet());
      repeat (2) send_packet(equal_packet(rand_field()));
    end

    // Back-to-back burst
    set_config(filter_gt, 4'b0001, 4'h0, 32'd0, identity_ops);
    repeat (64) send_packet(rand_packet());
    drain_pipe();
    repeat (2) @(negedge ap_clk);

    if (exp_q.size() != 0) begin
      protocol_errors++;
      $display("%0d expected packets never came out", exp_q.size());
    end
    check_count(pass_count, exp_pass_tally, "pass_count");
    check_count(drop_count, exp_drop_tally, "drop_count");

    $display("Run complete: %0d value errors, %0d protocol errors", value_errors,
             protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (cycle_count >= timeout_cycles);
    $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
    $display("Simulation FAILED");
    $finish;
  end

endmodule : tb_filter_cond_engine

//--- test/tb_clock_gen.sv
// --------------------
// Testbench clock source, 40 ns period
// --------------------

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter realtime period = 40ns
) (
  output logic ap_clk
);

  initial begin
    ap_clk = 1'b0;
    forever begin
      #(period / 2) ap_clk = ~ap_clk;
    end
  end

endmodule : tb_clock_gen

//--- logic/filter_cond_engine.sv
// --------------------
// Filter condition engine top level
// --------------------

`timescale 1ns/1ps

module filter_cond_engine (
  input  logic                                 ap_clk,
  input  logic                                 rst_n,
  input  logic                                 cfg_we,
  input  filter_cond_pkg::cfg_addr_t           cfg_addr,
  input  logic [31:0]                          cfg_wdata,
  input  logic                                 in_valid,
  input  filter_cond_pkg::engine_packet_data_t in_data,
  output logic                                 out_valid,
  output filter_cond_pkg::engine_packet_data_t out_data,
  output logic [31:0]                          pass_count,
  output logic [31:0]                          drop_count
);

  import filter_cond_pkg::*;

  // Decoded settings
  filter_op_t             filter_operation;
  logic [num_fields-1:0]  filter_mask;
  logic [num_fields-1:0]  const_mask;
  logic [field_width-1:0] const_value;
  ops_mask_t              ops_mask;

  // Kernel results
  engine_packet_data_t    result_data;
  logic                   result_pass;

  filter_cond_config u_config (
    .ap_clk           (ap_clk),
    .rst_n            (rst_n),
    .cfg_we           (cfg_we),
    .cfg_addr         (cfg_addr),
    .cfg_wdata        (cfg_wdata),
    .filter_operation (filter_operation),
    .filter_mask      (filter_mask),
    .const_mask       (const_mask),
    .const_value      (const_value),
    .ops_mask         (ops_mask)
  );

  filter_cond_kernel u_kernel (
    .ap_clk           (ap_clk),
    .in_data          (in_data),
    .filter_operation (filter_operation),
    .filter_mask      (filter_mask),
    .const_mask       (const_mask),
    .const_value      (const_value),
    .ops_mask         (ops_mask),
    .result_data      (result_data),
    .result_pass      (result_pass)
  );

  // Settings reach the gate only for the in-flight check
  filter_cond_gate u_gate (
    .ap_clk           (ap_clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .result_data      (result_data),
    .result_pass      (result_pass),
    .filter_operation (filter_operation),
    .filter_mask      (filter_mask),
    .const_mask       (const_mask),
    .const_value      (const_value),
    .ops_mask         (ops_mask),
    .out_valid        (out_valid),
    .out_data         (out_data),
    .pass_count       (pass_count),
    .drop_count       (drop_count)
  );

endmodule : filter_cond_engine

//--- logic/filter_cond_gate.sv
// --------------------
// Filter condition output gate
// Pass/drop decision and packet counters
// --------------------

`timescale 1ns/1ps

module filter_cond_gate (
  input  logic                                    ap_clk,
  input  logic                                    rst_n,
  input  logic                                    in_valid,
  input  filter_cond_pkg::engine_packet_data_t    result_data,
  input  logic                                    result_pass,
  input  filter_cond_pkg::filter_op_t             filter_operation,
  input  logic [filter_cond_pkg::num_fields-1:0]  filter_mask,
  input  logic [filter_cond_pkg::num_fields-1:0]  const_mask,
  input  logic [filter_cond_pkg::field_width-1:0] const_value,
  input  filter_cond_pkg::ops_mask_t              ops_mask,
  output logic                                    out_valid,
  output filter_cond_pkg::engine_packet_data_t    out_data,
  output logic [31:0]                             pass_count,
  output logic [31:0]                             drop_count
);

  import filter_cond_pkg::*;

  // Strobe travels alongside the kernel stages
  logic [kernel_latency-1:0] valid_pipe;
  logic                      valid_dly;

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[kernel_latency-2:0], in_valid};
    end
  end

  assign valid_dly = valid_pipe[kernel_latency-1];
  assign out_valid = valid_dly & result_pass;
  assign out_data  = result_data;

  // --------------------
  // Counters, free running and wrapping
  // --------------------
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      pass_count <= '0;
      drop_count <= '0;
    end else if (valid_dly) begin
      if (result_pass) begin
        pass_count <= pass_count + 32'd1;
      end else begin
        drop_count <= drop_count + 32'd1;
      end
    end
  end

  // Every output traces back to an accepted input
  a_out_has_input: assert property (
    @(posedge ap_clk) disable iff (!rst_n)
    out_valid |-> $past(in_valid, kernel_latency)
  ) else $error("out_valid without a matching input strobe");

  a_one_count_step: assert property (
    @(posedge ap_clk) disable iff (!rst_n)
    !($changed(pass_count) && $changed(drop_count))
  ) else $error("Pass and drop counted in the same cycle");

  // Packets in flight rely on the settings they entered with
  a_cfg_stable: assert property (
    @(posedge ap_clk) disable iff (!rst_n)
    (|valid_pipe) |-> ($stable(filter_operation) && $stable(filter_mask) &&
                       $stable(const_mask) && $stable(const_value) &&
                       $stable(ops_mask))
  ) else $error("Configuration changed with packets in flight");

endmodule : filter_cond_gate

//--- logic/filter_cond_kernel.sv
// --------------------
// Filter condition compare kernel
// Three-stage operand mapping and neighbour compare
// --------------------

`timescale 1ns/1ps

module filter_cond_kernel (
  input  logic                                    ap_clk,
  input  filter_cond_pkg::engine_packet_data_t    in_data,
  input  filter_cond_pkg::filter_op_t             filter_operation,
  input  logic [filter_cond_pkg::num_fields-1:0]  filter_mask,
  input  logic [filter_cond_pkg::num_fields-1:0]  const_mask,
  input  logic [filter_cond_pkg::field_width-1:0] const_value,
  input  filter_cond_pkg::ops_mask_t              ops_mask,
  output filter_cond_pkg::engine_packet_data_t    result_data,
  output logic                                    result_pass
);

  import filter_cond_pkg::*;

  // Stage 1 registers
  engine_packet_data_t   ops_value_reg;
  engine_packet_data_t   org_value_reg;
  filter_op_t            op_s1;
  logic [num_fields-1:0] filter_mask_s1;

  // Stage 2 registers
  engine_packet_data_t   result_reg;
  logic [num_fields-1:0] lane_flag_reg;
  logic [num_fields-1:0] filter_mask_s2;

  // Highest set bit of the row wins, an empty row keeps the own lane
  function automatic logic [field_width-1:0] select_field(
    input logic [num_fields-1:0] row,
    input engine_packet_data_t   data,
    input int unsigned           lane
  );
    logic [field_width-1:0] pick;
    pick = data[lane];
    for (int j = 0; j < num_fields; j++) begin
      if (row[j]) begin
        pick = data[j];
      end
    end
    return pick;
  endfunction

  // --------------------
  // Stage 1 operand mapping
  // --------------------
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < num_fields; i++) begin
      if (const_mask[i]) begin
        ops_value_reg[i] <= const_value;
      end else if (|ops_mask[i]) begin
        ops_value_reg[i] <= select_field(ops_mask[i], in_data, i);
      end else begin
        ops_value_reg[i] <= '0;
      end
      org_value_reg[i] <= select_field(ops_mask[i], in_data, i);
    end
    // Settings follow the packet down the pipe
    op_s1          <= filter_operation;
    filter_mask_s1 <= filter_mask;
  end

  // Stage 2 lane compares, lane i against lane (i+1) mod 4
  always_ff @(posedge ap_clk) begin
    filter_mask_s2 <= filter_mask_s1;
    case (op_s1)
      // --------------------
      filter_nop: begin
        // Operand vector leaves as is
        result_reg    <= ops_value_reg;
        lane_flag_reg <= '1;
      end
      // --------------------
      filter_gt: begin
        result_reg <= org_value_reg;
        for (int i = 0; i < num_fields; i++) begin
          lane_flag_reg[i] <= ops_value_reg[i] > ops_value_reg[(i + 1) % num_fields];
        end
      end
      // --------------------
      filter_lt: begin
        result_reg <= org_value_reg;
        for (int i = 0; i < num_fields; i++) begin
          lane_flag_reg[i] <= ops_value_reg[i] < ops_value_reg[(i + 1) % num_fields];
        end
      end
      // --------------------
      filter_eq: begin
        result_reg <= org_value_reg;
        for (int i = 0; i < num_fields; i++) begin
          lane_flag_reg[i] <= ops_value_reg[i] == ops_value_reg[(i + 1) % num_fields];
        end
      end
      // --------------------
      filter_not_eq: begin
        result_reg <= org_value_reg;
        for (int i = 0; i < num_fields; i++) begin
          lane_flag_reg[i] <= ops_value_reg[i] != ops_value_reg[(i + 1) % num_fields];
        end
      end
      // --------------------
      default: begin
        // Undefined codes pass the original vector through
        result_reg    <= org_value_reg;
        lane_flag_reg <= '1;
      end
    endcase
  end

  // --------------------
  // Stage 3 reduction
  // --------------------
  // Disabled lanes count as true, so an empty mask passes
  always_ff @(posedge ap_clk) begin
    result_data <= result_reg;
    result_pass <= &(lane_flag_reg | ~filter_mask_s2);
  end

endmodule : filter_cond_kernel

//--- logic/filter_cond_config.sv
// --------------------
// Filter condition register file
// Write strobes load the filter settings
// --------------------

`timescale 1ns/1ps

module filter_cond_config (
  input  logic                              ap_clk,
  input  logic                              rst_n,
  input  logic                              cfg_we,
  input  filter_cond_pkg::cfg_addr_t        cfg_addr,
  input  logic [31:0]                       cfg_wdata,
  output filter_cond_pkg::filter_op_t       filter_operation,
  output logic [filter_cond_pkg::num_fields-1:0]  filter_mask,
  output logic [filter_cond_pkg::num_fields-1:0]  const_mask,
  output logic [filter_cond_pkg::field_width-1:0] const_value,
  output filter_cond_pkg::ops_mask_t        ops_mask
);

  import filter_cond_pkg::*;

  // Bits of cfg_wdata that hold the ops mask, row i at [4i+3:4i]
  localparam int ops_mask_bits = num_fields * num_fields;

  // --------------------
  // Register writes
  // --------------------
  // Defaults give a no-operation filter with nothing selected
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      filter_operation <= filter_nop;
      filter_mask      <= '0;
      const_mask       <= '0;
      const_value      <= '0;
      ops_mask         <= '0;
    end else if (cfg_we) begin
      case (cfg_addr)
        cfg_operation: begin
          filter_operation <= filter_op_t'(cfg_wdata[2:0]);
        end
        cfg_filter_mask: begin
          filter_mask <= cfg_wdata[num_fields-1:0];
        end
        cfg_const_mask: begin
          const_mask <= cfg_wdata[num_fields-1:0];
        end
        cfg_const_value: begin
          const_value <= cfg_wdata[field_width-1:0];
        end
        cfg_ops_mask: begin
          ops_mask <= ops_mask_t'(cfg_wdata[ops_mask_bits-1:0]);
        end
        default: begin
          // Unused addresses leave every register alone
        end
      endcase
    end
  end

  // --------------------
  // Checks
  // --------------------
  // An unknown address would corrupt whichever register it aliases
  a_cfg_addr_known: assert property (
    @(posedge ap_clk) disable iff (!rst_n)
    cfg_we |-> !$isunknown(cfg_addr)
  ) else $error("Config write with unknown address");

endmodule : filter_cond_config

//--- logic/filter_cond_pkg.sv
// --------------------
// Filter condition shared definitions
// Packet layout, operation codes and register map
// --------------------

package filter_cond_pkg;

  // Packet geometry
  localparam int num_fields  = 4;
  localparam int field_width = 32;

  // Input strobe to result, in cycles
  localparam int kernel_latency = 3;

  // Packet payload, field i in bits [32i+31:32i]
  typedef logic [num_fields-1:0][field_width-1:0] engine_packet_data_t;

  // Row i picks the source field for lane i
  typedef logic [num_fields-1:0][num_fields-1:0] ops_mask_t;

  // --------------------
  // Compare operations
  // --------------------
  // Codes 5 to 7 are left undefined and act as pass-through
  typedef enum logic [2:0] {
    filter_nop    = 3'd0,
    filter_gt     = 3'd1,
    filter_lt     = 3'd2,
    filter_eq     = 3'd3,
    filter_not_eq = 3'd4
  } filter_op_t;

  // --------------------
  // Register addresses
  // --------------------
  typedef enum logic [2:0] {
    cfg_operation   = 3'd0,
    cfg_filter_mask = 3'd1,
    cfg_const_mask  = 3'd2,
    cfg_const_value = 3'd3,
    cfg_ops_mask    = 3'd4
  } cfg_addr_t;

endpackage : filter_cond_pkg
